/* verilog/decode_pkg.sv */
// decode_pkg
// shared widths, opcode map, field format codes, class stamps and the
// instruction word type for the decode stage

package decode_pkg;

    // widths
    localparam int WORD_W    = 32;
    localparam int OP_W      = 6;
    localparam int REG_IDX_W = 5;
    localparam int NUM_REGS  = 32;
    localparam int STAMP_W   = 3;
    localparam int FMT_W     = 3;
    localparam int RIMM_W    = 11;              // register view immediate
    localparam int UIMM_W    = 21;              // upper view immediate

    // arithmetic and logic
    localparam logic [OP_W-1:0] OP_ADD  = 6'b000000;
    localparam logic [OP_W-1:0] OP_SUB  = 6'b000001;
    localparam logic [OP_W-1:0] OP_AND  = 6'b000010;
    localparam logic [OP_W-1:0] OP_OR   = 6'b000011;
    localparam logic [OP_W-1:0] OP_XOR  = 6'b000100;
    localparam logic [OP_W-1:0] OP_SLT  = 6'b000101;
    // immediate, upper immediate and memory
    localparam logic [OP_W-1:0] OP_ADDI = 6'b000110;
    localparam logic [OP_W-1:0] OP_ANDI = 6'b000111;
    localparam logic [OP_W-1:0] OP_ORI  = 6'b001000;
    localparam logic [OP_W-1:0] OP_LUI  = 6'b001001;
    localparam logic [OP_W-1:0] OP_LB   = 6'b001100;
    localparam logic [OP_W-1:0] OP_SB   = 6'b001101;
    // branch and jump
    localparam logic [OP_W-1:0] OP_BEQ  = 6'b001110;
    localparam logic [OP_W-1:0] OP_BNE  = 6'b001111;
    localparam logic [OP_W-1:0] OP_BLEZ = 6'b010000;
    localparam logic [OP_W-1:0] OP_BGTZ = 6'b010001;
    localparam logic [OP_W-1:0] OP_J    = 6'b010010;
    localparam logic [OP_W-1:0] OP_JAL  = 6'b010011;
    // shifts, multiply and divide
    localparam logic [OP_W-1:0] OP_SLL  = 6'b010110;
    localparam logic [OP_W-1:0] OP_SRL  = 6'b010111;
    localparam logic [OP_W-1:0] OP_SRA  = 6'b011000;
    localparam logic [OP_W-1:0] OP_SAL  = 6'b011001;
    localparam logic [OP_W-1:0] OP_MULT = 6'b011110;
    localparam logic [OP_W-1:0] OP_DIV  = 6'b011111;
    // float ops
    localparam logic [OP_W-1:0] OP_FADD = 6'b100000;
    localparam logic [OP_W-1:0] OP_FSUB = 6'b100001;
    localparam logic [OP_W-1:0] OP_FMUL = 6'b100010;
    localparam logic [OP_W-1:0] OP_FDIV = 6'b100011;
    localparam logic [OP_W-1:0] OP_FGT  = 6'b100100;
    localparam logic [OP_W-1:0] OP_FLT  = 6'b100101;
    localparam logic [OP_W-1:0] OP_FEQ  = 6'b100110;
    localparam logic [OP_W-1:0] OP_FNE  = 6'b100111;
    localparam logic [OP_W-1:0] OP_FSQR = 6'b101000;
    // moves
    localparam logic [OP_W-1:0] OP_MOV  = 6'b101010;
    localparam logic [OP_W-1:0] OP_NOT  = 6'b101100;

    // field formats
    localparam logic [FMT_W-1:0] FMT_NONE  = 3'd0;
    localparam logic [FMT_W-1:0] FMT_RRR   = 3'd1;   // rs rt rd
    localparam logic [FMT_W-1:0] FMT_RI    = 3'd2;   // rs rd imm11
    localparam logic [FMT_W-1:0] FMT_RD    = 3'd3;   // rs rd
    localparam logic [FMT_W-1:0] FMT_UPPER = 3'd4;   // rd_hi imm21
    localparam logic [FMT_W-1:0] FMT_MEM   = 3'd5;   // rs rd, address via rt
    localparam logic [FMT_W-1:0] FMT_JUMP  = 3'd6;   // rs only

    // class stamps
    localparam logic [STAMP_W-1:0] STAMP_ALU   = 3'b010;
    localparam logic [STAMP_W-1:0] STAMP_UPPER = 3'b110;
    localparam logic [STAMP_W-1:0] STAMP_MEM   = 3'b001;
    localparam logic [STAMP_W-1:0] STAMP_FLOW  = 3'b011;
    localparam logic [STAMP_W-1:0] STAMP_NONE  = 3'b111;

    // one instruction word, register view or upper immediate view
    typedef union packed {
        struct packed {
            logic [OP_W-1:0]      op;
            logic [REG_IDX_W-1:0] rs;
            logic [REG_IDX_W-1:0] rt;
            logic [REG_IDX_W-1:0] rd;
            logic [RIMM_W-1:0]    imm;
        } r;
        struct packed {
            logic [OP_W-1:0]      op;
            logic [REG_IDX_W-1:0] rd_hi;
            logic [UIMM_W-1:0]    imm;
        } u;
    } instr_word_t;

endpackage

/* verilog/op_classifier.sv */
// op_classifier
// opcode table: gives each opcode its field format and class stamp,
// purely combinational

`timescale 1ns/1ps

module op_classifier (
    input  logic [decode_pkg::OP_W-1:0]    op,
    output logic [decode_pkg::FMT_W-1:0]   fmt,
    output logic [decode_pkg::STAMP_W-1:0] stamp
);
    import decode_pkg::*;

    always_comb begin
        fmt   = FMT_NONE;                       // unknown opcode
        stamp = STAMP_NONE;
        case (op)
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLT: begin
                fmt   = FMT_RRR;
                stamp = STAMP_ALU;
            end
            OP_SLL, OP_SRL, OP_SRA, OP_SAL, OP_MULT, OP_DIV: begin
                fmt   = FMT_RRR;
                stamp = STAMP_ALU;
            end
            OP_FADD, OP_FSUB, OP_FMUL, OP_FDIV: begin
                fmt   = FMT_RRR;
                stamp = STAMP_ALU;
            end
            OP_FGT, OP_FLT, OP_FEQ, OP_FNE: begin
                fmt   = FMT_RRR;                // compare result lands in rd
                stamp = STAMP_ALU;
            end
            OP_ADDI, OP_ANDI, OP_ORI: begin
                fmt   = FMT_RI;
                stamp = STAMP_ALU;
            end
            OP_LUI: begin
                fmt   = FMT_UPPER;
                stamp = STAMP_UPPER;
            end
            OP_LB, OP_SB: begin
                fmt   = FMT_MEM;
                stamp = STAMP_MEM;
            end
            OP_BEQ, OP_BNE: begin
                fmt   = FMT_RRR;
                stamp = STAMP_FLOW;
            end
            OP_BLEZ, OP_BGTZ: begin
                fmt   = FMT_RD;                 // compare against zero, no rt
                stamp = STAMP_FLOW;
            end
            OP_J: begin
                fmt   = FMT_JUMP;
                stamp = STAMP_FLOW;
            end
            // JAL writes a link register, so it is classed with the ALU ops
            OP_JAL: begin
                fmt   = FMT_RD;
                stamp = STAMP_ALU;
            end
            OP_FSQR, OP_MOV, OP_NOT: begin
                fmt   = FMT_RD;                 // single source ops
                stamp = STAMP_ALU;
            end
            default: begin
                fmt   = FMT_NONE;
                stamp = STAMP_NONE;
            end
        endcase
    end

endmodule

/* verilog/reg_file.sv */
// reg_file
// address registers read by LB/SB, one synchronous write port and one
// combinational read port

`timescale 1ns/1ps

module reg_file (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             wr_en,
    input  logic [decode_pkg::REG_IDX_W-1:0] wr_addr,
    input  logic [decode_pkg::WORD_W-1:0]    wr_data,
    input  logic [decode_pkg::REG_IDX_W-1:0] rd_addr,
    output logic [decode_pkg::WORD_W-1:0]    rd_data
);
    import decode_pkg::*;

    logic [WORD_W-1:0] regs [NUM_REGS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;                  // all entries clear
            end
        end else if (wr_en) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // read before write: same cycle read sees the old entry
    assign rd_data = regs[rd_addr];

endmodule

/* verilog/decode_stage.sv */
// decode_stage
// pulls the fields out of the instruction word by format and holds the
// decoded record in an output register with a valid/ready handshake

`timescale 1ns/1ps

module decode_stage (
    input  logic                              clk,
    input  logic                              rst,
    input  decode_pkg::instr_word_t           instr,
    input  logic                              instr_valid,
    output logic                              instr_ready,
    input  logic [decode_pkg::FMT_W-1:0]      fmt,
    input  logic [decode_pkg::STAMP_W-1:0]    stamp,
    input  logic [decode_pkg::WORD_W-1:0]     rd_data,
    output logic [decode_pkg::OP_W-1:0]       out_op,
    output logic [decode_pkg::REG_IDX_W-1:0]  out_rs,
    output logic [decode_pkg::REG_IDX_W-1:0]  out_rt,
    output logic [decode_pkg::REG_IDX_W-1:0]  out_rd,
    output logic [decode_pkg::WORD_W-1:0]     out_imm,
    output logic [decode_pkg::WORD_W-1:0]     out_addr,
    output logic [decode_pkg::STAMP_W-1:0]    out_stamp,
    output logic                              out_valid,
    input  logic                              out_ready
);
    import decode_pkg::*;

    logic [OP_W-1:0]      nxt_op;
    logic [REG_IDX_W-1:0] nxt_rs;
    logic [REG_IDX_W-1:0] nxt_rt;
    logic [REG_IDX_W-1:0] nxt_rd;
    logic [WORD_W-1:0]    nxt_imm;
    logic [WORD_W-1:0]    nxt_addr;
    logic [STAMP_W-1:0]   nxt_stamp;
    logic                 load;

    // room when empty or when the held record leaves this cycle
    assign instr_ready = !out_valid || out_ready;
    assign load        = instr_valid && instr_ready;

    always_comb begin
        nxt_op    = instr.r.op;
        nxt_rs    = '0;                         // unused fields stay zero
        nxt_rt    = '0;
        nxt_rd    = '0;
        nxt_imm   = '0;
        nxt_addr  = '0;
        nxt_stamp = stamp;
        case (fmt)
            FMT_RRR: begin
                nxt_rs = instr.r.rs;
                nxt_rt = instr.r.rt;
                nxt_rd = instr.r.rd;
            end
            FMT_RI: begin
                nxt_rs  = instr.r.rs;
                nxt_rd  = instr.r.rd;
                nxt_imm = {{(WORD_W-RIMM_W){1'b0}}, instr.r.imm};
            end
            FMT_RD: begin
                nxt_rs = instr.r.rs;
                nxt_rd = instr.r.rd;
            end
            FMT_UPPER: begin
                nxt_rd  = instr.u.rd_hi;
                nxt_imm = {{(WORD_W-UIMM_W){1'b0}}, instr.u.imm};
            end
            FMT_MEM: begin
                nxt_rs   = instr.r.rs;
                nxt_rd   = instr.r.rd;
                nxt_addr = rd_data;             // register at index rt
            end
            FMT_JUMP: begin
                nxt_rs = instr.r.rs;
            end
            default: begin
                nxt_op    = '0;                 // invalid, stamp only
                nxt_stamp = STAMP_NONE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
            out_op    <= '0;
            out_rs    <= '0;
            out_rt    <= '0;
            out_rd    <= '0;
            out_imm   <= '0;
            out_addr  <= '0;
            out_stamp <= STAMP_NONE;
        end else if (load) begin
            out_valid <= 1'b1;
            out_op    <= nxt_op;
            out_rs    <= nxt_rs;
            out_rt    <= nxt_rt;
            out_rd    <= nxt_rd;
            out_imm   <= nxt_imm;
            out_addr  <= nxt_addr;
            out_stamp <= nxt_stamp;
        end else if (out_ready) begin
            out_valid <= 1'b0;                  // drained, nothing new
        end
    end

endmodule

/* verilog/instr_decoder.sv */
// instr_decoder
// decode stage top: opcode classifier, address register file and the
// output register stage

`timescale 1ns/1ps

module instr_decoder (
    input  logic                              clk,
    input  logic                              rst,
    input  decode_pkg::instr_word_t           instr,
    input  logic                              instr_valid,
    output logic                              instr_ready,
    input  logic                              wr_en,
    input  logic [decode_pkg::REG_IDX_W-1:0]  wr_addr,
    input  logic [decode_pkg::WORD_W-1:0]     wr_data,
    output logic [decode_pkg::OP_W-1:0]       out_op,
    output logic [decode_pkg::REG_IDX_W-1:0]  out_rs,
    output logic [decode_pkg::REG_IDX_W-1:0]  out_rt,
    output logic [decode_pkg::REG_IDX_W-1:0]  out_rd,
    output logic [decode_pkg::WORD_W-1:0]     out_imm,
    output logic [decode_pkg::WORD_W-1:0]     out_addr,
    output logic [decode_pkg::STAMP_W-1:0]    out_stamp,
    output logic                              out_valid,
    input  logic                              out_ready
);
    import decode_pkg::*;

    logic [FMT_W-1:0]   fmt;
    logic [STAMP_W-1:0] stamp;
    logic [WORD_W-1:0]  rd_data;

    op_classifier u_classifier (
        .op    (instr.r.op),
        .fmt   (fmt),
        .stamp (stamp)
    );

    reg_file u_reg_file (
        .clk     (clk),
        .rst     (rst),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_addr (instr.r.rt),                  // LB/SB address index
        .rd_data (rd_data)
    );

    decode_stage u_stage (
        .clk         (clk),
        .rst         (rst),
        .instr       (instr),
        .instr_valid (instr_valid),
        .instr_ready (instr_ready),
        .fmt         (fmt),
        .stamp       (stamp),
        .rd_data     (rd_data),
        .out_op      (out_op),
        .out_rs      (out_rs),
        .out_rt      (out_rt),
        .out_rd      (out_rd),
        .out_imm     (out_imm),
        .out_addr    (out_addr),
        .out_stamp   (out_stamp),
        .out_valid   (out_valid),
        .out_ready   (out_ready)
    );

endmodule

/* tests/decoder_assert.sv */
// decoder_assert
// reset and valid/ready rules on the decoder outputs, bound to the top level

`timescale 1ns/1ps

module decoder_assert (
    input logic                             clk,
    input logic                             rst,
    input logic                             instr_ready,
    input logic [decode_pkg::OP_W-1:0]      out_op,
    input logic [decode_pkg::REG_IDX_W-1:0] out_rs,
    input logic [decode_pkg::REG_IDX_W-1:0] out_rt,
    input logic [decode_pkg::REG_IDX_W-1:0] out_rd,
    input logic [decode_pkg::WORD_W-1:0]    out_imm,
    input logic [decode_pkg::WORD_W-1:0]    out_addr,
    input logic [decode_pkg::STAMP_W-1:0]   out_stamp,
    input logic                             out_valid,
    input logic                             out_ready
);
    logic stall;

    assign stall = out_valid && !out_ready;     // record held downstream

    reset_clears_valid: assert property (@(posedge clk) rst |=> !out_valid)
        else $error("out_valid high in the cycle after reset");

    stall_holds_record: assert property (@(posedge clk) disable iff (rst)
        stall |=> out_valid && $stable(out_op) && $stable(out_rs) && $stable(out_rt)
            && $stable(out_rd) && $stable(out_imm) && $stable(out_addr)
            && $stable(out_stamp))
        else $error("decoded record changed under back-pressure");

    stall_blocks_input: assert property (@(posedge clk) disable iff (rst)
        stall |-> !instr_ready)
        else $error("instr_ready high under back-pressure");

endmodule

bind instr_decoder decoder_assert u_decoder_assert (
    .clk         (clk),
    .rst         (rst),
    .instr_ready (instr_ready),
    .out_op      (out_op),
    .out_rs      (out_rs),
    .out_rt      (out_rt),
    .out_rd      (out_rd),
    .out_imm     (out_imm),
    .out_addr    (out_addr),
    .out_stamp   (out_stamp),
    .out_valid   (out_valid),
    .out_ready   (out_ready)
);

/* tests/tb_instr_decoder.sv */
// tb_instr_decoder
// directed and random tests for the instruction decode stage checked
// against a field model built from the opcode format rules

`timescale 1ns/1ps

module tb_instr_decoder;
    import decode_pkg::*;

    localparam int TIMEOUT = 200;               // cycles per wait

    typedef struct packed {
        logic [OP_W-1:0]      op;
        logic [REG_IDX_W-1:0] rs;
        logic [REG_IDX_W-1:0] rt;
        logic [REG_IDX_W-1:0] rd;
        logic [WORD_W-1:0]    imm;
        logic [WORD_W-1:0]    addr;
        logic [STAMP_W-1:0]   stamp;
    } record_t;

    logic                 clk;
    logic                 rst;
    instr_word_t          instr;
    logic                 instr_valid;
    logic                 instr_ready;
    logic                 wr_en;
    logic [REG_IDX_W-1:0] wr_addr;
    logic [WORD_W-1:0]    wr_data;
    logic [OP_W-1:0]      out_op;
    logic [REG_IDX_W-1:0] out_rs;
    logic [REG_IDX_W-1:0] out_rt;
    logic [REG_IDX_W-1:0] out_rd;
    logic [WORD_W-1:0]    out_imm;
    logic [WORD_W-1:0]    out_addr;
    logic [STAMP_W-1:0]   out_stamp;
    logic                 out_valid;
    logic                 out_ready;

    logic [WORD_W-1:0] shadow [NUM_REGS];       // expected register contents
    record_t           expect_q [$];
    int                errors;
    logic              stall_mode;
    logic              pending;                 // input transfer at the last edge
    logic [31:0]       coin;

    instr_decoder DUT (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // random back-pressure only during the stream test
    always @(posedge clk) begin
        #1;
        coin = $urandom();
        out_ready = stall_mode ? coin[0] : 1'b1;
    end

    task automatic check_op(input string name, input logic [OP_W-1:0] got, exp);
        if (got !== exp) begin
            $display("FAIL %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_idx(input string name, input logic [REG_IDX_W-1:0] got, exp);
        if (got !== exp) begin
            $display("FAIL %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_word(input string name, input logic [WORD_W-1:0] got, exp);
        if (got !== exp) begin
            $display("FAIL %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_stamp(input string name, input logic [STAMP_W-1:0] got, exp);
        if (got !== exp) begin
            $display("FAIL %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic compare_record(input record_t e);
        check_op("out_op", out_op, e.op);
        check_idx("out_rs", out_rs, e.rs);
        check_idx("out_rt", out_rt, e.rt);
        check_idx("out_rd", out_rd, e.rd);
        check_word("out_imm", out_imm, e.imm);
        check_word("out_addr", out_addr, e.addr);
        check_stamp("out_stamp", out_stamp, e.stamp);
    endtask

    // expected record grouped by which fields each opcode uses
    function automatic record_t model_record(input instr_word_t w);
        record_t         e;
        logic [OP_W-1:0] op;
        op   = w.r.op;
        e    = '0;
        e.op = op;
        if (op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLT, OP_SLL, OP_SRL,
                       OP_SRA, OP_SAL, OP_MULT, OP_DIV, OP_FADD, OP_FSUB, OP_FMUL,
                       OP_FDIV, OP_FGT, OP_FLT, OP_FEQ, OP_FNE, OP_BEQ, OP_BNE}) begin
            e.rs    = w.r.rs;
            e.rt    = w.r.rt;
            e.rd    = w.r.rd;
            e.stamp = (op inside {OP_BEQ, OP_BNE}) ? STAMP_FLOW : STAMP_ALU;
        end else if (op inside {OP_ADDI, OP_ANDI, OP_ORI}) begin
            e.rs    = w.r.rs;
            e.rd    = w.r.rd;
            e.imm   = WORD_W'(w.r.imm);         // zero-extended 11 bits
            e.stamp = STAMP_ALU;
        end else if (op inside {OP_BLEZ, OP_BGTZ, OP_JAL, OP_FSQR, OP_MOV, OP_NOT}) begin
            e.rs    = w.r.rs;
            e.rd    = w.r.rd;
            e.stamp = (op inside {OP_BLEZ, OP_BGTZ}) ? STAMP_FLOW : STAMP_ALU;
        end else if (op == OP_LUI) begin
            e.rd    = w.u.rd_hi;
            e.imm   = WORD_W'(w.u.imm);
            e.stamp = STAMP_UPPER;
        end else if (op inside {OP_LB, OP_SB}) begin
            e.rs    = w.r.rs;
            e.rd    = w.r.rd;
            e.addr  = shadow[w.r.rt];
            e.stamp = STAMP_MEM;
        end else if (op == OP_J) begin
            e.rs    = w.r.rs;
            e.stamp = STAMP_FLOW;
        end else begin
            e.op    = '0;                       // unknown opcode
            e.stamp = STAMP_NONE;
        end
        return e;
    endfunction

    // outputs are stable at the falling edge
    always @(negedge clk) begin
        if (rst) begin
            pending = 1'b0;
        end else begin
            if (pending && !out_valid) begin
                $display("no record one cycle after its input transfer");
                errors++;
            end
            if (out_valid && expect_q.size() == 0) begin
                $display("output valid while no record was expected");
                errors++;
            end else if (out_valid) begin
                compare_record(expect_q[0]);    // also checks held records
                if (out_ready) expect_q.delete(0);
            end
            pending = instr_valid && instr_ready;
        end
    end

    task automatic write_reg(input logic [REG_IDX_W-1:0] idx, input logic [WORD_W-1:0] val);
        wr_en   = 1'b1;
        wr_addr = idx;
        wr_data = val;
        @(posedge clk);
        #1;
        wr_en       = 1'b0;
        shadow[idx] = val;
    endtask

    task automatic send_instr(input instr_word_t w);
        int waited;
        waited      = 0;
        instr       = w;
        instr_valid = 1'b1;
        @(negedge clk);
        while (!instr_ready && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (instr_ready) begin
            expect_q.push_back(model_record(w));
        end else begin
            $display("timed out waiting for instr_ready");
            errors++;
        end
        @(posedge clk);
        #1;
        instr_valid = 1'b0;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while ((expect_q.size() != 0 || out_valid) && waited < TIMEOUT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (expect_q.size() != 0 || out_valid) begin
            $display("timed out waiting for the output to drain");
            errors++;
        end
    endtask

    task automatic test_reset_state();
        if (out_valid !== 1'b0 || instr_ready !== 1'b1) begin
            $display("handshake not idle after reset");
            errors++;
        end
        compare_record('{op: '0, rs: '0, rt: '0, rd: '0, imm: '0, addr: '0,
                         stamp: STAMP_NONE});
    endtask

    task automatic test_three_reg();
        logic [OP_W-1:0] ops [6];
        ops = '{OP_ADD, OP_SLT, OP_SLL, OP_MULT, OP_FADD, OP_FNE};
        foreach (ops[i]) begin
            write_reg(REG_IDX_W'(i + 9), 32'h8000_0100 + i);    // rt registers not zero
        end
        foreach (ops[i]) begin
            send_instr({ops[i], REG_IDX_W'(i + 1), REG_IDX_W'(i + 9),
                        REG_IDX_W'(31 - i), 11'h5a5});  // imm bits must be dropped
        end
        wait_drain();
    endtask

    task automatic test_imm_forms();
        send_instr({OP_ADDI, 5'd3, 5'd7, 5'd4, 11'h7ff});
        send_instr({OP_ANDI, 5'd31, 5'd31, 5'd1, 11'h001});
        send_instr({OP_ORI, 5'd8, 5'd2, 5'd30, 11'h400});
        send_instr({OP_LUI, 5'd17, 21'h1f_ffff});
        send_instr({OP_LUI, 5'd2, 21'h0a_bcde});
        wait_drain();
    endtask

    task automatic test_mem_addr();
        write_reg(5'd5, 32'hdead_beef);
        write_reg(5'd9, 32'h0000_1000);
        send_instr({OP_LB, 5'd1, 5'd5, 5'd2, 11'h123});
        send_instr({OP_SB, 5'd3, 5'd9, 5'd4, 11'h000});
        write_reg(5'd5, 32'h1234_5678);         // next LB sees the new address
        send_instr({OP_LB, 5'd6, 5'd5, 5'd7, 11'h3ff});
        wait_drain();
    endtask

    task automatic test_flow_ops();
        logic [OP_W-1:0] ops [9];
        ops = '{OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ, OP_J, OP_JAL, OP_MOV, OP_NOT, OP_FSQR};
        write_reg(5'd13, 32'h0bad_f00d);        // rt register not zero
        foreach (ops[i]) begin
            send_instr({ops[i], REG_IDX_W'(i + 20), 5'd13, REG_IDX_W'(i + 2), 11'h2aa});
        end
        wait_drain();
    endtask

    task automatic test_unknown_ops();
        send_instr({6'b101001, 5'd1, 5'd2, 5'd3, 11'h7ff});
        send_instr({6'b111111, 5'd31, 5'd31, 5'd31, 11'h7ff});
        send_instr({6'b001010, 5'd4, 5'd5, 5'd6, 11'h001});
        wait_drain();
    endtask

    task automatic test_random_stream(input int count);
        logic [31:0] word;
        logic [31:0] gap;
        for (int i = 0; i < 8; i++) begin
            word = $urandom();
            write_reg(word[4:0], $urandom());
        end
        stall_mode = 1'b1;
        for (int i = 0; i < count; i++) begin
            word = $urandom();
            send_instr(word);
            gap = $urandom();
            for (int g = 0; g < int'(gap[1:0]); g++) begin
                @(posedge clk);
                #1;
            end
        end
        wait_drain();
        stall_mode = 1'b0;
    endtask

    initial begin
        void'($urandom(60985));
        rst         = 1'b1;
        instr       = '0;
        instr_valid = 1'b0;
        wr_en       = 1'b0;
        wr_addr     = '0;
        wr_data     = '0;
        out_ready   = 1'b1;
        stall_mode  = 1'b0;
        pending     = 1'b0;
        errors      = 0;
        foreach (shadow[i]) shadow[i] = '0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        test_reset_state();
        test_three_reg();
        test_imm_forms();
        test_mem_addr();
        test_flow_ops();
        test_unknown_ops();
        test_random_stream(150);
        $display("errors: %0d, records left: %0d", errors, expect_q.size());
        if (errors == 0 && expect_q.size() == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* vlog.f */
verilog/decode_pkg.sv
verilog/op_classifier.sv
verilog/reg_file.sv
verilog/decode_stage.sv
verilog/instr_decoder.sv
tests/decoder_assert.sv
tests/tb_instr_decoder.sv

/* Makefile */
# Verilator build and run for the instruction decoder testbench

VERILATOR ?= verilator
TOP       ?= tb_instr_decoder
FLIST     ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# the simulator status is ignored, the log decides
run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "Test OK" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
